/* verilog/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    typedef logic [31:0] u32_t;

    // store width, as encoded by the core
    typedef enum logic [1:0] {
        BYTE,
        HALF_WORD,
        WORD
    } byte_type_t;

    // single-beat AXI3 channel payloads
    typedef struct packed {
        logic [3:0] id;
        u32_t       addr;
        logic [7:0] len;
        logic [2:0] size;
        logic [1:0] burst;
    } axi_ar_t;

    typedef struct packed {
        logic [3:0] id;
        u32_t       addr;
        logic [7:0] len;
        logic [2:0] size;
        logic [1:0] burst;
    } axi_aw_t;

    typedef struct packed {
        logic [3:0] id;
        u32_t       data;
        logic [3:0] strb;
        logic       last;
    } axi_w_t;

    typedef struct packed {
        logic [3:0] id;
        u32_t       data;
        logic [1:0] resp;
        logic       last;
    } axi_r_t;

    typedef struct packed {
        logic [3:0] id;
        logic [1:0] resp;
    } axi_b_t;

    // port tags echoed back by the slave
    localparam logic [3:0] AXI_ID_IFETCH = 4'd0;
    localparam logic [3:0] AXI_ID_DATA = 4'd1;

    localparam logic [2:0] AXI_SIZE_WORD = 3'b010;
    localparam logic [1:0] AXI_BURST_INCR = 2'b01;

endpackage

`default_nettype wire

/* verilog/uncached_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module uncached_bridge (
    input  wire logic                clk,
    input  wire logic                rst_n,

    input  wire logic                ifetch_req,
    input  wire logic                ifetch_stall,
    input  mem_pkg::u32_t            ifetch_addr,
    output mem_pkg::u32_t            ifetch_data,
    output logic                     ifetch_busy,
    output logic                     ifetch_valid,

    input  wire logic                data_req,
    input  wire logic                data_store,
    input  wire logic                data_stall,
    input  mem_pkg::u32_t            data_addr,
    input  mem_pkg::byte_type_t      data_size,
    input  mem_pkg::u32_t            data_wdata,
    output mem_pkg::u32_t            data_rdata,
    output logic                     data_busy,
    output logic                     data_valid,

    output mem_pkg::axi_ar_t         ar,
    output logic                     arvalid,
    input  wire logic                arready,
    input  mem_pkg::axi_r_t          r,
    input  wire logic                rvalid,
    output logic                     rready,
    output mem_pkg::axi_aw_t         aw,
    output logic                     awvalid,
    input  wire logic                awready,
    output mem_pkg::axi_w_t          w,
    output logic                     wvalid,
    input  wire logic                wready,
    input  mem_pkg::axi_b_t          b,
    input  wire logic                bvalid,
    output logic                     bready
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_RD_ADDR,
        S_RD_DATA,
        S_WR_ADDR,
        S_WR_DATA,
        S_WR_RESP
    } state_t;

    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_IFETCH,
        OWN_DATA_RD,
        OWN_DATA_WR
    } owner_t;

    state_t state, state_next;
    owner_t owner, owner_next;

    mem_pkg::u32_t       addr_q;
    mem_pkg::u32_t       wdata_q;
    mem_pkg::byte_type_t size_q;
    logic [3:0]          strb;
    logic                port_stall;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
            owner <= OWN_NONE;
        end else begin
            state <= state_next;
            owner <= owner_next;
        end
    end

    // request payload, captured while idle
    always_ff @(posedge clk) begin
        if (state == S_IDLE) begin
            addr_q <= data_req ? data_addr : ifetch_addr;
            size_q <= data_size;
            wdata_q <= data_wdata;
        end
    end

    always_comb begin
        unique case (size_q)
            mem_pkg::BYTE:      strb = 4'b0001 << addr_q[1:0];
            mem_pkg::HALF_WORD: strb = 4'b0011 << addr_q[1:0];
            mem_pkg::WORD:      strb = 4'b1111;
            default:            strb = 4'b0000;
        endcase
    end

    assign port_stall = (owner == OWN_IFETCH) ? ifetch_stall : data_stall;

    always_comb begin
        state_next = state;
        owner_next = owner;
        arvalid = 1'b0;
        rready = 1'b0;
        awvalid = 1'b0;
        wvalid = 1'b0;
        bready = 1'b0;

        case (state)
            S_IDLE: begin
                owner_next = OWN_NONE;
                if (data_req) begin
                    if (data_store) begin
                        owner_next = OWN_DATA_WR;
                        state_next = S_WR_ADDR;
                    end else begin
                        owner_next = OWN_DATA_RD;
                        state_next = S_RD_ADDR;
                    end
                end else if (ifetch_req) begin
                    owner_next = OWN_IFETCH;
                    state_next = S_RD_ADDR;
                end
            end
            S_RD_ADDR: begin
                arvalid = 1'b1;
                if (arready) begin
                    state_next = S_RD_DATA;
                end
            end
            S_RD_DATA: begin
                // owning port can hold the response off
                rready = rvalid && !port_stall;
                if (rready) begin
                    state_next = S_IDLE;
                    owner_next = OWN_NONE;
                end
            end
            S_WR_ADDR: begin
                awvalid = 1'b1;
                if (awready) begin
                    state_next = S_WR_DATA;
                end
            end
            S_WR_DATA: begin
                wvalid = 1'b1;
                if (wready) begin
                    state_next = S_WR_RESP;
                end
            end
            S_WR_RESP: begin
                bready = 1'b1;
                if (bvalid) begin
                    state_next = S_IDLE;
                    owner_next = OWN_NONE;
                end
            end
            default: begin
                state_next = S_IDLE;
                owner_next = OWN_NONE;
            end
        endcase
    end

    always_comb begin
        ar.id = (owner == OWN_IFETCH) ? mem_pkg::AXI_ID_IFETCH : mem_pkg::AXI_ID_DATA;
        ar.addr = addr_q;
        ar.len = 8'd0;
        ar.size = mem_pkg::AXI_SIZE_WORD;
        ar.burst = mem_pkg::AXI_BURST_INCR;

        // stores only come from the data port
        aw.id = mem_pkg::AXI_ID_DATA;
        aw.addr = addr_q;
        aw.len = 8'd0;
        aw.size = mem_pkg::AXI_SIZE_WORD;
        aw.burst = mem_pkg::AXI_BURST_INCR;

        w.id = mem_pkg::AXI_ID_DATA;
        w.data = wdata_q;
        w.strb = strb;
        w.last = 1'b1;
    end

    assign data_busy = (owner != OWN_NONE);
    assign ifetch_busy = data_busy || data_req;

    assign ifetch_valid = rready && (owner == OWN_IFETCH);
    assign data_valid = rready && (owner == OWN_DATA_RD);

    // full word back, alignment is done in the core
    assign ifetch_data = r.data;
    assign data_rdata = r.data;

endmodule

`default_nettype wire

/* verilog/axi_sram.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_sram #(
    parameter int MEM_WORDS = 256,
    parameter int RESP_DELAY = 2
) (
    input  wire logic          clk,
    input  wire logic          rst_n,

    input  mem_pkg::axi_ar_t   ar,
    input  wire logic          arvalid,
    output logic               arready,
    output mem_pkg::axi_r_t    r,
    output logic               rvalid,
    input  wire logic          rready,
    input  mem_pkg::axi_aw_t   aw,
    input  wire logic          awvalid,
    output logic               awready,
    input  mem_pkg::axi_w_t    w,
    input  wire logic          wvalid,
    output logic               wready,
    output mem_pkg::axi_b_t    b,
    output logic               bvalid,
    input  wire logic          bready
);

    localparam int IDX_W = $clog2(MEM_WORDS);
    localparam int CNT_W = $clog2(RESP_DELAY) + 1;

    typedef enum logic [1:0] {
        S_IDLE,
        S_READ,
        S_WR_DATA,
        S_WR_RESP
    } state_t;

    state_t state;

    logic [CNT_W-1:0] cnt;
    logic [IDX_W-1:0] idx_q;
    logic [3:0]       id_q;
    mem_pkg::u32_t    rdata_q;
    mem_pkg::u32_t    mem [MEM_WORDS];

    assign arready = (state == S_IDLE);
    // reads win if both address channels are valid together
    assign awready = (state == S_IDLE) && !arvalid;
    assign wready = (state == S_WR_DATA);
    assign rvalid = (state == S_READ) && (cnt == '0);
    assign bvalid = (state == S_WR_RESP);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
            cnt <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (arvalid) begin
                        state <= S_READ;
                        cnt <= CNT_W'(RESP_DELAY - 1);
                    end else if (awvalid) begin
                        state <= S_WR_DATA;
                    end
                end
                S_READ: begin
                    if (cnt != '0) begin
                        cnt <= cnt - CNT_W'(1);
                    end else if (rready) begin
                        state <= S_IDLE;
                    end
                end
                S_WR_DATA: begin
                    if (wvalid) begin
                        state <= S_WR_RESP;
                    end
                end
                S_WR_RESP: begin
                    if (bready) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            id_q <= ar.id;
            idx_q <= ar.addr[2 +: IDX_W];
            // nothing can write until this read completes
            rdata_q <= mem[ar.addr[2 +: IDX_W]];
        end else if (awvalid && awready) begin
            id_q <= aw.id;
            idx_q <= aw.addr[2 +: IDX_W];
        end
        if (wvalid && wready) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (w.strb[lane]) begin
                    mem[idx_q][lane*8 +: 8] <= w.data[lane*8 +: 8];
                end
            end
        end
    end

    // resp is always OKAY
    assign r.id = id_q;
    assign r.data = rdata_q;
    assign r.resp = 2'b00;
    assign r.last = 1'b1;

    assign b.id = id_q;
    assign b.resp = 2'b00;

endmodule

`default_nettype wire

/* verilog/uncached_mem_top.sv */
`timescale 1ns/1ps
`default_nettype none

module uncached_mem_top #(
    parameter int MEM_WORDS = 256,
    parameter int RESP_DELAY = 2
) (
    input  wire logic            clk,
    input  wire logic            rst_n,

    input  wire logic            ifetch_req,
    input  wire logic            ifetch_stall,
    input  mem_pkg::u32_t        ifetch_addr,
    output mem_pkg::u32_t        ifetch_data,
    output logic                 ifetch_busy,
    output logic                 ifetch_valid,

    input  wire logic            data_req,
    input  wire logic            data_store,
    input  wire logic            data_stall,
    input  mem_pkg::u32_t        data_addr,
    input  mem_pkg::byte_type_t  data_size,
    input  mem_pkg::u32_t        data_wdata,
    output mem_pkg::u32_t        data_rdata,
    output logic                 data_busy,
    output logic                 data_valid
);

    mem_pkg::axi_ar_t ar;
    mem_pkg::axi_aw_t aw;
    mem_pkg::axi_w_t  w;
    mem_pkg::axi_r_t  r;
    mem_pkg::axi_b_t  b;

    logic arvalid, arready;
    logic awvalid, awready;
    logic wvalid, wready;
    logic rvalid, rready;
    logic bvalid, bready;

    uncached_bridge bridge_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .ifetch_req   (ifetch_req),
        .ifetch_stall (ifetch_stall),
        .ifetch_addr  (ifetch_addr),
        .ifetch_data  (ifetch_data),
        .ifetch_busy  (ifetch_busy),
        .ifetch_valid (ifetch_valid),
        .data_req     (data_req),
        .data_store   (data_store),
        .data_stall   (data_stall),
        .data_addr    (data_addr),
        .data_size    (data_size),
        .data_wdata   (data_wdata),
        .data_rdata   (data_rdata),
        .data_busy    (data_busy),
        .data_valid   (data_valid),
        .ar           (ar),
        .arvalid      (arvalid),
        .arready      (arready),
        .r            (r),
        .rvalid       (rvalid),
        .rready       (rready),
        .aw           (aw),
        .awvalid      (awvalid),
        .awready      (awready),
        .w            (w),
        .wvalid       (wvalid),
        .wready       (wready),
        .b            (b),
        .bvalid       (bvalid),
        .bready       (bready)
    );

    axi_sram #(
        .MEM_WORDS  (MEM_WORDS),
        .RESP_DELAY (RESP_DELAY)
    ) sram_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .ar      (ar),
        .arvalid (arvalid),
        .arready (arready),
        .r       (r),
        .rvalid  (rvalid),
        .rready  (rready),
        .aw      (aw),
        .awvalid (awvalid),
        .awready (awready),
        .w       (w),
        .wvalid  (wvalid),
        .wready  (wready),
        .b       (b),
        .bvalid  (bvalid),
        .bready  (bready)
    );

endmodule

`default_nettype wire

/* sim/tb_uncached_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_uncached_mem;

    logic                clk = 1'b0;
    logic                rst_n;
    logic                ifetch_req;
    logic                ifetch_stall;
    mem_pkg::u32_t       ifetch_addr;
    mem_pkg::u32_t       ifetch_data;
    logic                ifetch_busy;
    logic                ifetch_valid;
    logic                data_req;
    logic                data_store;
    logic                data_stall;
    mem_pkg::u32_t       data_addr;
    mem_pkg::byte_type_t data_size;
    mem_pkg::u32_t       data_wdata;
    mem_pkg::u32_t       data_rdata;
    logic                data_busy;
    logic                data_valid;

    logic [31:0] rng_state = 32'd54;
    logic [7:0]  shadow [1024];
    logic [31:0] known [$];
    string       cur_test;
    int          test_errors;
    int          tests_passed;
    int          tests_failed;

    uncached_mem_top dut_i (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic [31:0] pick_known();
        logic [31:0] rnd;
        rnd = next_rand();
        return known[rnd % known.size()];
    endfunction

    // byte lanes follow size and the low address bits
    function automatic void apply_store(input logic [31:0] addr,
                                        input mem_pkg::byte_type_t size,
                                        input logic [31:0] wdata);
        int base;
        int off;
        bit en;
        base = int'(addr[9:2]) * 4;
        off = int'(addr[1:0]);
        for (int lane = 0; lane < 4; lane++) begin
            if (size == mem_pkg::WORD) begin
                en = 1'b1;
            end else if (size == mem_pkg::HALF_WORD) begin
                en = (lane == off) || (lane == off + 1);
            end else begin
                en = (lane == off);
            end
            if (en) begin
                shadow[base + lane] = wdata[lane*8 +: 8];
            end
        end
    endfunction

    function automatic logic [31:0] shadow_word(input logic [31:0] addr);
        int base;
        base = int'(addr[9:2]) * 4;
        return {shadow[base + 3], shadow[base + 2], shadow[base + 1], shadow[base]};
    endfunction

    task automatic report_error(input string msg);
        $display("ERROR in %s: %s", cur_test, msg);
        test_errors++;
    endtask

    task automatic check_word(input string what, input logic [31:0] exp,
                              input logic [31:0] act);
        assert (act === exp) else begin
            $display("MISMATCH %s %s: expected %08h actual %08h", cur_test, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            $display("%s: ok", cur_test);
            tests_passed++;
        end else begin
            $display("%s: failed with %0d errors", cur_test, test_errors);
            tests_failed++;
        end
    endtask

    task automatic store_data(input logic [31:0] addr, input mem_pkg::byte_type_t size,
                              input logic [31:0] wdata);
        int cycles;
        @(posedge clk);
        #0.5;
        data_req = 1'b1;
        data_store = 1'b1;
        data_addr = addr;
        data_size = size;
        data_wdata = wdata;
        @(posedge clk);
        #0.5;
        data_req = 1'b0;
        data_store = 1'b0;
        apply_store(addr, size, wdata);
        cycles = 0;
        @(negedge clk);
        assert (data_busy) else
            report_error("data_busy did not rise after the store request");
        while (data_busy && cycles < 200) begin
            @(negedge clk);
            cycles++;
        end
        if (data_busy) begin
            report_error("timeout waiting for data_busy to fall after a store");
        end
    endtask

    // one read on either port with the stall held for stall_cycles
    task automatic read_word(input bit fetch, input logic [31:0] addr,
                             input int stall_cycles, output logic [31:0] data);
        int cycles;
        int pulses;
        int stall_left;
        @(posedge clk);
        #0.5;
        if (fetch) begin
            ifetch_req = 1'b1;
            ifetch_addr = addr;
            ifetch_stall = (stall_cycles > 0);
        end else begin
            data_req = 1'b1;
            data_addr = addr;
            data_size = mem_pkg::WORD;
            data_stall = (stall_cycles > 0);
        end
        @(posedge clk);
        #0.5;
        ifetch_req = 1'b0;
        data_req = 1'b0;
        stall_left = stall_cycles;
        cycles = 0;
        pulses = 0;
        data = '0;
        while (pulses == 0 && cycles < 200) begin
            @(negedge clk);
            assert (!(fetch ? data_valid : ifetch_valid)) else
                report_error("valid pulsed on the port that did not request");
            assert (!(fetch ? ifetch_stall && ifetch_valid : data_stall && data_valid)) else
                report_error("valid pulsed while the port was stalled");
            if (fetch ? ifetch_valid : data_valid) begin
                pulses++;
                data = fetch ? ifetch_data : data_rdata;
            end
            if (stall_left > 0) begin
                stall_left--;
            end
            @(posedge clk);
            #0.5;
            if (stall_left == 0) begin
                ifetch_stall = 1'b0;
                data_stall = 1'b0;
            end
            cycles++;
        end
        if (pulses == 0) begin
            report_error("timeout waiting for read valid");
        end
        @(negedge clk);
        assert (!ifetch_valid && !data_valid) else
            report_error("read valid pulsed more than once");
    endtask

    task automatic check_idle();
        check_word("busy and valid flags", 32'd0,
                   {28'd0, ifetch_busy, data_busy, ifetch_valid, data_valid});
    endtask

    initial begin
        logic [31:0] rnd;
        logic [31:0] addr;
        logic [31:0] addr_b;
        logic [31:0] got;
        int data_at;
        int fetch_at;
        int cycles;
        rst_n = 1'b0;
        ifetch_req = 1'b0;
        ifetch_stall = 1'b0;
        ifetch_addr = '0;
        data_req = 1'b0;
        data_store = 1'b0;
        data_stall = 1'b0;
        data_addr = '0;
        data_size = mem_pkg::WORD;
        data_wdata = '0;
        tests_passed = 0;
        tests_failed = 0;

        start_test("reset_idle");
        repeat (8) begin
            @(negedge clk);
            check_idle();
        end
        @(posedge clk);
        #0.5;
        rst_n = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_idle();
        end
        finish_test();

        start_test("word_store_load");
        repeat (32) begin
            rnd = next_rand();
            addr = {22'd0, rnd[7:0], 2'b00};
            known.push_back(addr);
            store_data(addr, mem_pkg::WORD, next_rand());
            read_word(1'b0, addr, 0, got);
            check_word("load after word store", shadow_word(addr), got);
        end
        finish_test();

        start_test("sub_word_merge");
        repeat (24) begin
            rnd = next_rand();
            addr = pick_known();
            if (rnd[2]) begin
                addr[1:0] = {rnd[1], 1'b0};
                store_data(addr, mem_pkg::HALF_WORD, next_rand());
            end else begin
                addr[1:0] = rnd[1:0];
                store_data(addr, mem_pkg::BYTE, next_rand());
            end
            addr[1:0] = 2'b00;
            read_word(1'b0, addr, 0, got);
            check_word("merged word", shadow_word(addr), got);
        end
        finish_test();

        start_test("ifetch_read_and_priority");
        addr = pick_known();
        read_word(1'b1, addr, 0, got);
        check_word("plain fetch", shadow_word(addr), got);
        addr = pick_known();
        addr_b = pick_known();
        @(posedge clk);
        #0.5;
        data_req = 1'b1;
        data_addr = addr;
        ifetch_req = 1'b1;
        ifetch_addr = addr_b;
        data_at = 0;
        fetch_at = 0;
        cycles = 0;
        while ((data_at == 0 || fetch_at == 0) && cycles < 200) begin
            @(negedge clk);
            cycles++;
            assert (!data_req || ifetch_busy) else
                report_error("ifetch_busy low while data_req is high");
            if (data_valid) begin
                data_at = cycles;
                check_word("data load", shadow_word(addr), data_rdata);
            end
            if (ifetch_valid) begin
                fetch_at = cycles;
                check_word("fetch", shadow_word(addr_b), ifetch_data);
            end
            @(posedge clk);
            #0.5;
            // drop each request once its transfer is under way
            if (data_busy) begin
                data_req = 1'b0;
            end
            if (data_at != 0 && data_busy) begin
                ifetch_req = 1'b0;
            end
        end
        if (data_at == 0 || fetch_at == 0) begin
            report_error("timeout waiting for both valid pulses");
        end else begin
            assert (data_at < fetch_at) else
                report_error("ifetch_valid came before data_valid");
        end
        finish_test();

        start_test("stall_hold");
        repeat (12) begin
            rnd = next_rand();
            addr = pick_known();
            read_word(rnd[0], addr, 1 + int'(rnd[15:8] % 8'd10), got);
            check_word("stalled read", shadow_word(addr), got);
        end
        finish_test();

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* uncached_mem.f */
verilog/mem_pkg.sv
verilog/uncached_bridge.sv
verilog/axi_sram.sv
verilog/uncached_mem_top.sv
sim/tb_uncached_mem.sv

/* run_sim.sh */
#!/bin/sh
# build and run the uncached_mem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f uncached_mem.f \
    --top-module tb_uncached_mem -o sim_tb_uncached_mem
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb_uncached_mem)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "TEST RESULT: PASS"; then
    exit 0
fi
exit 1
